// ==== i2c_reg_master.f ====
design/i2c_bus_pkg.sv
design/i2c_req_pkg.sv
design/i2c_byte_engine.sv
design/i2c_reg_sequencer.sv
design/i2c_reg_master.sv
testbench/i2c_slave_model.sv
testbench/i2c_reg_master_asserts.sv
testbench/tb_i2c_reg_master.sv

// ==== Bender.yml ====
package:
  name: i2c_reg_master

sources:
  - design/i2c_bus_pkg.sv
  - design/i2c_req_pkg.sv
  - design/i2c_byte_engine.sv
  - design/i2c_reg_sequencer.sv
  - design/i2c_reg_master.sv
  - target: test
    files:
      - testbench/i2c_slave_model.sv
      - testbench/i2c_reg_master_asserts.sv
      - testbench/tb_i2c_reg_master.sv

// ==== testbench/tb_i2c_reg_master.sv ====
/*
 Testbench for the register master with one slave model at 7'h50 on the bus.
 A full register access takes about 10000 system clocks at 100 kHz SCL.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_reg_master
	import i2c_req_pkg::*;
();

	logic sys_clk;
	logic sys_rst_n;
	i2c_req_t req;
	logic req_valid;
	logic busy;
	i2c_resp_t resp;
	logic resp_valid;
	wire scl;
	wire sda;
	wire [6:0] slave_addr = 7'h50;

	// Expected contents of the slave registers
	logic [7:0] image [256];
	int check_count = 0;
	int err_count = 0;
	int timeout_count = 0;
	int resp_count = 0;
	int expected_resps = 0;

	i2c_reg_master dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.req        (req),
		.req_valid  (req_valid),
		.busy       (busy),
		.resp       (resp),
		.resp_valid (resp_valid),
		.scl        (scl),
		.sda        (sda)
	);

	i2c_slave_model u_slave (
		.scl      (scl),
		.sda      (sda),
		.dev_addr (slave_addr)
	);

	pullup (sda);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#20 sys_clk = ~sys_clk;
		end
	end

	always @(posedge sys_clk) begin
		if (resp_valid === 1'b1) begin
			resp_count <= resp_count + 1;
		end
	end

	task automatic compare_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		check_count++;
		assert (cond === 1'b1) else begin
			err_count++;
			$display("%s", what);
		end
	endtask

	task automatic send_request(input req_op_e kind, input logic [6:0] dev,
		input logic [7:0] addr, input logic [7:0] data);
		@(posedge sys_clk);
		req <= '{op: kind, dev_addr: dev, reg_addr: addr, wdata: data};
		req_valid <= 1'b1;
		@(posedge sys_clk);
		req_valid <= 1'b0;
	endtask

	task automatic wait_response(output logic ok);
		int waited;
		waited = 0;
		while (resp_valid !== 1'b1 && waited < 20000) begin
			@(posedge sys_clk);
			waited++;
		end
		ok = (resp_valid === 1'b1);
		if (ok) begin
			expected_resps++;
		end else begin
			timeout_count++;
			$display("no response arrived within 20000 cycles");
		end
	endtask

	// Watches for a response that should never come
	task automatic expect_no_response(input int cycles);
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < cycles) begin
			@(posedge sys_clk);
			seen = (resp_valid === 1'b1);
			waited++;
		end
		expect_true(!seen, "a request made while busy got a response");
	endtask

	task automatic write_reg(input logic [6:0] dev, input logic [7:0] addr,
		input logic [7:0] data, input logic nack_exp);
		logic ok;
		send_request(op_reg_write, dev, addr, data);
		wait_response(ok);
		if (ok) begin
			compare_value("resp.nack", resp.nack, nack_exp);
			if (!nack_exp) begin
				image[addr] = data;
			end
		end
	endtask

	task automatic read_reg(input logic [6:0] dev, input logic [7:0] addr,
		input logic nack_exp);
		logic ok;
		send_request(op_reg_read, dev, addr, 8'h00);
		wait_response(ok);
		if (ok) begin
			compare_value("resp.nack", resp.nack, nack_exp);
			if (!nack_exp) begin
				compare_value("resp.rdata", resp.rdata, image[addr]);
			end
		end
	endtask

	task automatic check_bus_released();
		compare_value("scl", scl, 1'b1);
		compare_value("sda", sda, 1'b1);
	endtask

	initial begin
		logic [7:0] addr;
		logic [7:0] data;
		logic ok;
		int seed_ret;
		int assert_fails;
		seed_ret = $urandom(32'h3e62);
		sys_rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		for (int i = 0; i < 256; i++) begin
			image[i] = 8'(i) ^ 8'hA5;
		end
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		// Idle bus and no busy before the first request
		repeat (10) begin
			@(posedge sys_clk);
			compare_value("busy", busy, 1'b0);
		end
		check_bus_released();

		write_reg(slave_addr, 8'h12, 8'h9e, 1'b0);
		read_reg(slave_addr, 8'h12, 1'b0);
		read_reg(slave_addr, 8'hc3, 1'b0);

		// Nobody answers at 7'h23
		write_reg(7'h23, 8'h10, 8'h77, 1'b1);
		check_bus_released();
		read_reg(7'h23, 8'h10, 1'b1);
		check_bus_released();
		write_reg(slave_addr, 8'h10, 8'h5a, 1'b0);
		read_reg(slave_addr, 8'h10, 1'b0);

		send_request(op_reg_write, slave_addr, 8'h3c, 8'h11);
		@(posedge sys_clk);
		compare_value("busy", busy, 1'b1);
		// The second strobe lands while the first write is still running
		send_request(op_reg_write, slave_addr, 8'h3c, 8'h22);
		wait_response(ok);
		if (ok) begin
			compare_value("resp.nack", resp.nack, 1'b0);
		end
		image[8'h3c] = 8'h11;
		expect_no_response(12000);
		compare_value("busy", busy, 1'b0);
		read_reg(slave_addr, 8'h3c, 1'b0);

		for (int n = 0; n < 20; n++) begin
			addr = 8'h80 + 8'($urandom % 8);
			data = 8'($urandom);
			if ($urandom % 2 == 0) begin
				write_reg(slave_addr, addr, data, 1'b0);
			end else begin
				read_reg(slave_addr, addr, 1'b0);
			end
		end

		repeat (10) @(posedge sys_clk);
		expect_true(resp_count == expected_resps, "response count differs from requests made");
		assert_fails = dut.u_asserts.fail_count;
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			check_count, err_count, timeout_count, assert_fails);
		if (err_count == 0 && timeout_count == 0 && assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/i2c_reg_master_asserts.sv ====
/*
 Bus and host timing checks, bound into the register master.
 Engine state is read from the engine instance inside the top level.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_master_asserts
	import i2c_bus_pkg::*;
(
	input wire           sys_clk,
	input wire           sys_rst_n,
	input wire           scl,
	input wire           sda,
	input wire           busy,
	input wire           resp_valid,
	input engine_state_e eng_state
);

	int fail_count = 0;

	// Under a high SCL the data line moves only for start and stop conditions
	sda_hold_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && !$stable(sda)) |-> (eng_state inside {st_start, st_stop}))
	else begin
		fail_count++;
		$error("sda changed while scl was high outside a start or stop");
	end

	resp_pulse_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		resp_valid |=> !resp_valid)
	else begin
		fail_count++;
		$error("resp_valid lasted more than one cycle");
	end

	busy_fall_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(busy) |-> resp_valid)
	else begin
		fail_count++;
		$error("busy fell without resp_valid");
	end

	resp_busy_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		resp_valid |-> $fell(busy))
	else begin
		fail_count++;
		$error("resp_valid came without busy falling");
	end

endmodule

bind i2c_reg_master i2c_reg_master_asserts u_asserts (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.scl        (scl),
	.sda        (sda),
	.busy       (busy),
	.resp_valid (resp_valid),
	.eng_state  (u_engine.state)
);

`default_nettype wire

// ==== testbench/i2c_slave_model.sv ====
/*
 Behavioral I2C slave with 256 byte registers on one 7-bit device address.
 The register pointer advances after each data byte. No clock stretching.
 Registers start at their own address XOR 8'hA5.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model (
	input  wire       scl,
	inout  wire       sda,
	input  wire [6:0] dev_addr
);

	typedef enum logic [2:0] {
		ph_idle,
		ph_addr,
		ph_reg,
		ph_wdata,
		ph_rdata
	} phase_e;

	logic [7:0] regs [256];
	phase_e phase;
	logic [7:0] shift;
	logic [7:0] tx_byte;
	logic [7:0] ptr;
	logic read_dir;
	logic master_nack;
	logic sda_low;
	logic scl_q;
	logic sda_q;
	int bit_cnt;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++) begin
			regs[i] = 8'(i) ^ 8'hA5;
		end
		phase = ph_idle;
		sda_low = 1'b0;
		bit_cnt = 0;
		ptr = 8'h00;
		scl_q = 1'b1;
		sda_q = 1'b1;
	end

	// SDA is only driven after SCL falls, so its own edges never look like start or stop
	always @(scl or sda) begin
		if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
			phase = ph_addr;
			bit_cnt = 0;
			sda_low <= 1'b0;
		end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
			phase = ph_idle;
			sda_low <= 1'b0;
		end else if (scl_q === 1'b0 && scl === 1'b1 && phase != ph_idle) begin
			if (bit_cnt < 8) begin
				shift = {shift[6:0], (sda !== 1'b0)};
			end else if (phase == ph_rdata) begin
				master_nack = (sda !== 1'b0);
			end
			bit_cnt++;
		end else if (scl_q === 1'b1 && scl === 1'b0 && phase != ph_idle) begin
			if (bit_cnt == 8) begin
				case (phase)
					ph_addr: begin
						if (shift[7:1] == dev_addr) begin
							read_dir = shift[0];
							sda_low <= 1'b1;
						end else begin
							// Not addressed, so stay off the bus until the next start
							phase = ph_idle;
						end
					end
					ph_reg: begin
						ptr = shift;
						sda_low <= 1'b1;
					end
					ph_wdata: begin
						regs[ptr] = shift;
						ptr++;
						sda_low <= 1'b1;
					end
					default: sda_low <= 1'b0;
				endcase
			end else if (bit_cnt == 9) begin
				bit_cnt = 0;
				if (phase == ph_addr && read_dir) begin
					phase = ph_rdata;
					tx_byte = regs[ptr];
					sda_low <= !tx_byte[7];
				end else if (phase == ph_addr) begin
					phase = ph_reg;
					sda_low <= 1'b0;
				end else if (phase == ph_reg) begin
					phase = ph_wdata;
					sda_low <= 1'b0;
				end else if (phase == ph_rdata && !master_nack) begin
					ptr++;
					tx_byte = regs[ptr];
					sda_low <= !tx_byte[7];
				end else begin
					if (phase == ph_rdata) begin
						phase = ph_idle;
					end
					sda_low <= 1'b0;
				end
			end else if (phase == ph_rdata) begin
				sda_low <= !tx_byte[7 - bit_cnt];
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

`default_nettype wire

// ==== design/i2c_reg_master.sv ====
/*
 Register access I2C master for one-byte writes and reads.
 SDA needs an external pull-up. Bus rate is set in i2c_bus_pkg.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_master
	import i2c_bus_pkg::*;
	import i2c_req_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  i2c_req_t  req,
	input  logic      req_valid,
	output logic      busy,
	output i2c_resp_t resp,
	output logic      resp_valid,
	output logic      scl,
	inout  wire       sda
);

	i2c_cmd_t cmd;
	logic cmd_vld;
	logic [7:0] wr_data;
	logic [7:0] rd_data;
	logic rd_data_vld;
	logic rev_ack;
	logic done;

	i2c_reg_sequencer u_seq (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.busy        (busy),
		.resp        (resp),
		.resp_valid  (resp_valid),
		.cmd         (cmd),
		.cmd_vld     (cmd_vld),
		.wr_data     (wr_data),
		.done        (done),
		.rev_ack     (rev_ack),
		.rd_data_vld (rd_data_vld),
		.rd_data     (rd_data)
	);

	i2c_byte_engine u_engine (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cmd         (cmd),
		.cmd_vld     (cmd_vld),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.rd_data_vld (rd_data_vld),
		.rev_ack     (rev_ack),
		.done        (done),
		.scl         (scl),
		.sda         (sda)
	);

endmodule

`default_nettype wire

// ==== design/i2c_reg_sequencer.sv ====
/*
 Splits one register request into engine commands and collects the result.
 Requests arriving while busy are dropped. A NACK ends the transfer with a stop.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_sequencer
	import i2c_bus_pkg::*;
	import i2c_req_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  i2c_req_t   req,
	input  logic       req_valid,
	output logic       busy,
	output i2c_resp_t  resp,
	output logic       resp_valid,
	output i2c_cmd_t   cmd,
	output logic       cmd_vld,
	output logic [7:0] wr_data,
	input  logic       done,
	input  logic       rev_ack,
	input  logic       rd_data_vld,
	input  logic [7:0] rd_data
);

	typedef enum logic [2:0] {
		step_addr_w,
		step_reg,
		step_data_stop,
		step_re_addr_r,
		step_read_stop,
		step_abort_stop,
		step_finish
	} step_e;

	step_e step;
	i2c_req_t req_r;
	logic nack_w;
	logic [7:0] rdata_w;
	logic accept;
	logic finishing;

	assign accept = req_valid && !busy;
	assign finishing = busy && (step == step_finish);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			step <= step_finish;
			cmd_vld <= 1'b0;
			resp_valid <= 1'b0;
			nack_w <= 1'b0;
		end else begin
			cmd_vld <= 1'b0;
			resp_valid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				step <= step_addr_w;
				cmd_vld <= 1'b1;
				nack_w <= 1'b0;
			end else if (finishing) begin
				busy <= 1'b0;
				resp_valid <= 1'b1;
			end else if (busy && done) begin
				case (step)
					step_addr_w, step_re_addr_r: begin
						cmd_vld <= 1'b1;
						if (rev_ack) begin
							nack_w <= 1'b1;
							step <= step_abort_stop;
						end else begin
							step <= (step == step_addr_w) ? step_reg : step_read_stop;
						end
					end
					step_reg: begin
						cmd_vld <= 1'b1;
						if (rev_ack) begin
							nack_w <= 1'b1;
							step <= step_abort_stop;
						end else if (req_r.op == op_reg_write) begin
							step <= step_data_stop;
						end else begin
							step <= step_re_addr_r;
						end
					end
					// The data byte already carried its own stop
					step_data_stop: begin
						nack_w <= rev_ack;
						step <= step_finish;
					end
					default: step <= step_finish;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			req_r <= req;
			rdata_w <= '0;
		end else if (rd_data_vld) begin
			rdata_w <= rd_data;
		end
	end

	// Response only changes when a new one is reported
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			resp <= '0;
		end else if (finishing) begin
			resp.rdata <= rdata_w;
			resp.nack <= nack_w;
		end
	end

	always_comb begin
		cmd = '0;
		wr_data = '0;
		case (step)
			step_addr_w: begin
				cmd.start = 1'b1;
				cmd.write = 1'b1;
				wr_data = {req_r.dev_addr, 1'b0};
			end
			step_reg: begin
				cmd.write = 1'b1;
				wr_data = req_r.reg_addr;
			end
			step_data_stop: begin
				cmd.write = 1'b1;
				cmd.stop = 1'b1;
				wr_data = req_r.wdata;
			end
			step_re_addr_r: begin
				cmd.start = 1'b1;
				cmd.write = 1'b1;
				wr_data = {req_r.dev_addr, 1'b1};
			end
			step_read_stop: begin
				// Single byte read, so the master answers with NACK
				cmd.read = 1'b1;
				cmd.stop = 1'b1;
				cmd.nack = 1'b1;
			end
			step_abort_stop: cmd.stop = 1'b1;
			default: cmd = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/i2c_byte_engine.sv ====
/*
 Bit-level I2C engine. Accepts a command only while idle and pulses done when it ends.
 SCL is driven push-pull and is not checked for clock stretching.
 SDA needs an external pull-up, the engine only pulls it low or lets it go.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine
	import i2c_bus_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  i2c_cmd_t   cmd,
	input  logic       cmd_vld,
	input  logic [7:0] wr_data,
	output logic [7:0] rd_data,
	output logic       rd_data_vld,
	output logic       rev_ack,
	output logic       done,
	output logic       scl,
	inout  wire        sda
);

	engine_state_e state;
	engine_state_e state_nxt;
	i2c_cmd_t cmd_r;
	logic [7:0] wr_data_r;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [2:0] slot_cnt;
	logic [2:0] slot_last;
	logic cmd_take;
	logic busy_slot;
	logic end_bit;
	logic end_slot;
	logic at_set;
	logic at_sample;
	logic sda_low;
	logic sda_in;

	assign sda = sda_low ? 1'b0 : 1'bz;
	assign sda_in = sda;

	assign cmd_take = cmd_vld && (state == st_idle);
	assign busy_slot = (state != st_idle);

	assign end_bit = busy_slot && (bit_cnt == BIT_CNT_W'(BIT_CLKS - 1));
	// Data states span eight slots, all the others a single one
	assign slot_last = ((state == st_wr_data) || (state == st_rd_data)) ? 3'd7 : 3'd0;
	assign end_slot = end_bit && (slot_cnt == slot_last);

	assign at_set = busy_slot && (bit_cnt == BIT_CNT_W'(SDA_SET_CNT));
	assign at_sample = busy_slot && (bit_cnt == BIT_CNT_W'(SDA_SAMPLE_CNT));

	// A command is over whenever the machine heads back to idle
	assign done = busy_slot && (state_nxt == st_idle);
	assign rd_data_vld = done && cmd_r.read;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cmd_r <= '0;
		end else if (cmd_take) begin
			cmd_r <= cmd;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cmd_take) begin
			wr_data_r <= wr_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
			slot_cnt <= '0;
		end else if (end_bit) begin
			bit_cnt <= '0;
			slot_cnt <= end_slot ? 3'd0 : slot_cnt + 3'd1;
		end else if (busy_slot) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				// Stop alone from idle closes a transfer that ended on a NACK
				if (cmd_vld) begin
					if (cmd.start) begin
						state_nxt = st_start;
					end else if (cmd.write) begin
						state_nxt = st_wr_data;
					end else if (cmd.read) begin
						state_nxt = st_rd_data;
					end else if (cmd.stop) begin
						state_nxt = st_stop;
					end
				end
			end
			st_start: begin
				if (end_slot) begin
					if (cmd_r.write) begin
						state_nxt = st_wr_data;
					end else if (cmd_r.read) begin
						state_nxt = st_rd_data;
					end else begin
						state_nxt = st_idle;
					end
				end
			end
			st_wr_data: begin
				if (end_slot) begin
					state_nxt = st_r_ack;
				end
			end
			st_rd_data: begin
				if (end_slot) begin
					state_nxt = st_t_ack;
				end
			end
			st_r_ack, st_t_ack: begin
				if (end_slot) begin
					state_nxt = cmd_r.stop ? st_stop : st_idle;
				end
			end
			st_stop: begin
				if (end_slot) begin
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	// SCL stays high after a stop and low between all other commands
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl <= 1'b1;
		end else if (busy_slot && (bit_cnt == BIT_CNT_W'(SCL_RISE_CNT))) begin
			scl <= 1'b1;
		end else if (end_bit && (state != st_stop)) begin
			scl <= 1'b0;
		end
	end

	// Only start and stop touch SDA while SCL is high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_low <= 1'b0;
		end else if (at_set) begin
			case (state)
				st_start: sda_low <= 1'b0;
				st_wr_data: sda_low <= !wr_data_r[3'd7 - slot_cnt];
				st_rd_data: sda_low <= 1'b0;
				st_r_ack: sda_low <= 1'b0;
				st_t_ack: sda_low <= !cmd_r.nack;
				st_stop: sda_low <= 1'b1;
				default: sda_low <= sda_low;
			endcase
		end else if (at_sample) begin
			if (state == st_start) begin
				sda_low <= 1'b1;
			end else if (state == st_stop) begin
				sda_low <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rev_ack <= 1'b0;
		end else if (at_sample && (state == st_r_ack)) begin
			rev_ack <= sda_in;
		end
	end

	// Received bits come in MSB first
	always_ff @(posedge sys_clk) begin
		if (at_sample && (state == st_rd_data)) begin
			rd_data <= {rd_data[6:0], sda_in};
		end
	end

endmodule

`default_nettype wire

// ==== design/i2c_req_pkg.sv ====
/*
 Host side request and response of the register master.
 One register byte per request and 7-bit device addresses only.
*/
`default_nettype none

package i2c_req_pkg;

	typedef enum logic {
		op_reg_write,
		op_reg_read
	} req_op_e;

	// One register access as the host asks for it
	typedef struct packed {
		req_op_e op;
		logic [6:0] dev_addr;
		logic [7:0] reg_addr;
		// Ignored for reads
		logic [7:0] wdata;
	} i2c_req_t;

	// Result of one register access
	typedef struct packed {
		// Zero after a write
		logic [7:0] rdata;
		// Set when the device did not acknowledge one of the bytes
		logic nack;
	} i2c_resp_t;

endpackage

`default_nettype wire

// ==== design/i2c_bus_pkg.sv ====
/*
 Bus timing for a 25 MHz system clock and a 100 kHz SCL, fixed at build time.
 Command flags may be combined, start with write or read with stop and nack.
 The flag order puts start in bit 0 and nack in bit 4.
*/
`default_nettype none

package i2c_bus_pkg;

	localparam int SYS_CLK_HZ = 25_000_000;
	localparam int SCL_HZ = 100_000;

	// System clocks in one bit slot on the bus
	localparam int BIT_CLKS = SYS_CLK_HZ / SCL_HZ;
	localparam int BIT_CNT_W = $clog2(BIT_CLKS);

	// SCL goes high halfway through the slot and low again when the slot ends
	localparam int SCL_RISE_CNT = BIT_CLKS / 2;

	// SDA is set in the middle of the low phase and read in the middle of the high phase
	localparam int SDA_SET_CNT = BIT_CLKS / 4;
	localparam int SDA_SAMPLE_CNT = (BIT_CLKS * 3) / 4;

	// Engine command, one flag per bus action
	typedef struct packed {
		logic nack;
		logic stop;
		logic read;
		logic write;
		logic start;
	} i2c_cmd_t;

	// Engine states, one per kind of bit slot
	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_wr_data,
		st_rd_data,
		st_r_ack,
		st_t_ack,
		st_stop
	} engine_state_e;

endpackage

`default_nettype wire
